/* hw/fc_config.svh */
// fc engine sizing: word width, lane count, RAM depth, accumulator and pipeline depth
`ifndef FC_CONFIG_SVH
`define FC_CONFIG_SVH

// stream and RAM word, four feature bytes per word
`define FC_WORD_W 32

// output neurons, one MAC lane and one weight bank each
`define FC_LANES 4

// words per RAM
`define FC_FEAT_DEPTH 256

// signed accumulator width
`define FC_ACC_W 24

// fraction bits dropped before the clip to 0..127
`define FC_FRAC_SHIFT 6

// register stages in the multiplier before the accumulator
`define FC_MUL_LAT 4

`endif

/* hw/fc_pkg.sv */
// fc engine types shared by the control, datapath and packer
`include "fc_config.svh"

package fc_pkg;

  // one stream beat or RAM word
  typedef logic [`FC_WORD_W-1:0] word_t;

  // feature or weight operand
  typedef logic signed [7:0] byte_t;

  // per-lane running sum
  typedef logic signed [`FC_ACC_W-1:0] acc_t;

  // word address into any of the RAMs
  typedef logic [$clog2(`FC_FEAT_DEPTH)-1:0] addr_t;

  // command code, strobed with cmd_valid
  typedef enum logic [1:0] {
    load_feat = 2'd1,
    load_wt   = 2'd2,
    run       = 2'd3
  } cmd_e;

  // feature byte count, up to 4 * depth inclusive
  typedef logic [$clog2(4 * `FC_FEAT_DEPTH):0] count_t;

endpackage

/* hw/word_ram.sv */
// single-port synchronous word RAM, one-cycle read latency
`timescale 1ns/1ns
`include "fc_config.svh"

module word_ram #(
  parameter int DEPTH = `FC_FEAT_DEPTH
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [`FC_WORD_W-1:0]    din,
  output logic [`FC_WORD_W-1:0]    dout
);

  logic [`FC_WORD_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end
      dout <= mem[addr];  // read-first on a write
    end
  end

endmodule

/* hw/fc_ctrl.sv */
// fc engine control FSM: stream loads, paced fetches, drain wait and output handshake
`timescale 1ns/1ns
`include "fc_config.svh"

module fc_ctrl (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 cmd_valid,
  input  fc_pkg::cmd_e         cmd,
  input  fc_pkg::count_t       feat_count,
  input  logic                 s_valid,
  input  logic                 s_last,
  input  logic                 feed_idle,
  input  logic                 sent,
  output logic                 s_ready,
  output fc_pkg::addr_t        ram_addr,
  output logic                 feat_we,
  output logic [`FC_LANES-1:0] wt_we,
  output logic                 ram_en,
  output logic                 fetch,
  output logic                 fetch_first,
  output logic                 fetch_last,
  output logic                 pack_go,
  output logic                 load_done,
  output logic                 run_done
);
  import fc_pkg::*;

  // last drain count, pack_go follows on the next cycle
  localparam logic [3:0] drain_last = 4'(`FC_MUL_LAT + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_load_feat,
    st_load_wt,
    st_fetch,
    st_drain,
    st_send
  } state_e;

  state_e                        state;
  addr_t                         last_idx;  // words per vector minus one
  logic [$clog2(`FC_LANES)-1:0]  bank;
  logic [1:0]                    pace;      // one fetch per four feed cycles
  logic [3:0]                    drain_cnt;
  logic                          beat;

  ///////////////////////////////
  // strobes to RAMs and feed
  ///////////////////////////////

  assign beat        = s_valid && s_ready;
  assign feat_we     = (state == st_load_feat) && beat;
  assign wt_we       = (state == st_load_wt && beat) ?
                       ({{(`FC_LANES-1){1'b0}}, 1'b1} << bank) : '0;
  assign fetch       = (state == st_fetch) && (pace == 2'd0);
  assign fetch_first = fetch && (ram_addr == '0);
  assign fetch_last  = fetch && (ram_addr == last_idx);
  assign ram_en      = feat_we || (|wt_we) || fetch;

  ///////////////////////////////
  // state machine
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= st_idle;
      s_ready   <= 1'b0;
      ram_addr  <= '0;
      last_idx  <= '0;
      bank      <= '0;
      pace      <= '0;
      drain_cnt <= '0;
      pack_go   <= 1'b0;
      load_done <= 1'b0;
      run_done  <= 1'b0;
    end else begin
      load_done <= 1'b0;  // single-cycle pulses
      run_done  <= 1'b0;
      pack_go   <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            ram_addr  <= '0;
            bank      <= '0;
            pace      <= '0;
            drain_cnt <= '0;
            case (cmd)
              load_feat: begin
                state    <= st_load_feat;
                s_ready  <= 1'b1;
                last_idx <= addr_t'((feat_count >> 2) - count_t'(1));
              end
              load_wt: begin
                state   <= st_load_wt;
                s_ready <= 1'b1;
              end
              run:     state <= st_fetch;
              default: state <= st_idle;
            endcase
          end
        end
        st_load_feat: begin
          if (beat) begin
            ram_addr <= ram_addr + 1'b1;
            if (s_last) begin
              s_ready   <= 1'b0;
              load_done <= 1'b1;
              state     <= st_idle;
            end
          end
        end
        st_load_wt: begin
          if (beat) begin
            // next bank after a full run of words
            if (ram_addr == last_idx) begin
              ram_addr <= '0;
              bank     <= bank + 1'b1;
            end else begin
              ram_addr <= ram_addr + 1'b1;
            end
            if (s_last) begin
              s_ready   <= 1'b0;
              load_done <= 1'b1;
              state     <= st_idle;
            end
          end
        end
        st_fetch: begin
          pace <= pace + 1'b1;
          if (fetch) begin
            if (fetch_last) state <= st_drain;
            else ram_addr <= ram_addr + 1'b1;
          end
        end
        st_drain: begin
          if (feed_idle) begin  // count only once the lanes are done
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == drain_last) begin
              pack_go <= 1'b1;
              state   <= st_send;
            end
          end
        end
        st_send: begin
          if (sent) begin
            run_done <= 1'b1;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* hw/operand_feed.sv */
// operand feed: latches fetched words and walks the four byte lanes into the MACs
`timescale 1ns/1ns

module operand_feed (
  input  logic          clk,
  input  logic          rstn,
  input  logic          fetch,
  input  logic          fetch_first,
  input  logic          fetch_last,
  input  fc_pkg::word_t feat_word,
  input  fc_pkg::word_t wt_word0,
  input  fc_pkg::word_t wt_word1,
  input  fc_pkg::word_t wt_word2,
  input  fc_pkg::word_t wt_word3,
  output logic          lane_valid,
  output logic          first_word,
  output fc_pkg::byte_t feat_byte,
  output fc_pkg::byte_t wt_byte0,
  output fc_pkg::byte_t wt_byte1,
  output fc_pkg::byte_t wt_byte2,
  output fc_pkg::byte_t wt_byte3,
  output logic          feed_idle
);
  import fc_pkg::*;

  logic       fetch_d;   // RAM data valid this cycle
  logic       first_d;
  logic       last_d;
  logic       active;
  logic       first_q;
  logic       last_q;
  logic [1:0] lane;
  logic [4:0] bit_ofs;
  word_t      feat_q;
  word_t      wt_q0;
  word_t      wt_q1;
  word_t      wt_q2;
  word_t      wt_q3;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      fetch_d   <= 1'b0;
      first_d   <= 1'b0;
      last_d    <= 1'b0;
      active    <= 1'b0;
      first_q   <= 1'b0;
      last_q    <= 1'b0;
      lane      <= '0;
      feed_idle <= 1'b1;
    end else begin
      fetch_d <= fetch;
      first_d <= fetch_first;
      last_d  <= fetch_last;
      if (fetch) feed_idle <= 1'b0;
      if (fetch_d) begin
        active  <= 1'b1;
        lane    <= '0;
        first_q <= first_d;
        last_q  <= last_d;
      end else if (active) begin
        lane <= lane + 1'b1;
        if (lane == 2'd3) begin
          active <= 1'b0;
          if (last_q) feed_idle <= 1'b1;  // last byte of the vector issued
        end
      end
    end
  end

  // word holding registers
  always_ff @(posedge clk) begin
    if (fetch_d) begin
      feat_q <= feat_word;
      wt_q0  <= wt_word0;
      wt_q1  <= wt_word1;
      wt_q2  <= wt_word2;
      wt_q3  <= wt_word3;
    end
  end

  assign bit_ofs    = {lane, 3'b000};
  assign lane_valid = active;
  assign first_word = active && first_q && (lane == 2'd0);
  assign feat_byte  = byte_t'(feat_q[bit_ofs +: 8]);  // broadcast to every lane
  assign wt_byte0   = byte_t'(wt_q0[bit_ofs +: 8]);
  assign wt_byte1   = byte_t'(wt_q1[bit_ofs +: 8]);
  assign wt_byte2   = byte_t'(wt_q2[bit_ofs +: 8]);
  assign wt_byte3   = byte_t'(wt_q3[bit_ofs +: 8]);

endmodule

/* hw/mac_pe.sv */
// MAC lane: sign-magnitude 8x8 multiply through a pipelined adder tree, then accumulate
`timescale 1ns/1ns
`include "fc_config.svh"

module mac_pe (
  input  logic          clk,
  input  logic          rstn,
  input  logic          in_valid,
  input  logic          first,
  input  fc_pkg::byte_t a,
  input  fc_pkg::byte_t b,
  output fc_pkg::acc_t  acc
);
  import fc_pkg::*;

  localparam int lat = `FC_MUL_LAT;

  logic [7:0]     a_mag;
  logic [7:0]     b_mag;
  logic [7:0]     pp [8];    // partial products, row i weighs 2^i
  logic [7:0]     pp_q [8];
  logic [9:0]     s2_q [4];  // row pairs, weight 4^j
  logic [11:0]    s3_q [2];  // weight 16^k
  logic [15:0]    s4_q;      // unsigned product magnitude
  logic [lat-1:0] vld_pipe;
  logic [lat-1:0] fst_pipe;
  logic [lat-1:0] sgn_pipe;
  acc_t           prod;

  ///////////////////////////////
  // magnitudes and partials
  ///////////////////////////////

  assign a_mag = a[7] ? ~a + 8'd1 : a;  // -128 maps to 8'h80
  assign b_mag = b[7] ? ~b + 8'd1 : b;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pp[i] = b_mag[i] ? a_mag : 8'd0;
    end
  end

  ///////////////////////////////
  // adder tree
  ///////////////////////////////

  always_ff @(posedge clk) begin
    pp_q     <= pp;
    sgn_pipe <= {sgn_pipe[lat-2:0], a[7] ^ b[7]};
    for (int j = 0; j < 4; j++) begin
      s2_q[j] <= {2'b00, pp_q[2*j]} + {1'b0, pp_q[2*j+1], 1'b0};
    end
    for (int k = 0; k < 2; k++) begin
      s3_q[k] <= {2'b00, s2_q[2*k]} + {s2_q[2*k+1], 2'b00};
    end
    s4_q <= {4'd0, s3_q[0]} + {s3_q[1], 4'd0};
  end

  // sign restored at the end of the tree
  assign prod = sgn_pipe[lat-1] ? -acc_t'(s4_q) : acc_t'(s4_q);

  ///////////////////////////////
  // accumulator
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_pipe <= '0;
      fst_pipe <= '0;
      acc      <= '0;
    end else begin
      vld_pipe <= {vld_pipe[lat-2:0], in_valid};
      fst_pipe <= {fst_pipe[lat-2:0], in_valid && first};
      if (vld_pipe[lat-1]) begin
        acc <= fst_pipe[lat-1] ? prod : acc + prod;  // restart on a new vector
      end
    end
  end

endmodule

/* hw/result_pack.sv */
// output packer: clip and saturate four sums, hold the word until the stream takes it
`timescale 1ns/1ns
`include "fc_config.svh"

module result_pack (
  input  logic          clk,
  input  logic          rstn,
  input  logic          pack_go,
  input  fc_pkg::acc_t  acc0,
  input  fc_pkg::acc_t  acc1,
  input  fc_pkg::acc_t  acc2,
  input  fc_pkg::acc_t  acc3,
  input  logic          m_ready,
  output logic          m_valid,
  output fc_pkg::word_t m_data,
  output logic          sent
);
  import fc_pkg::*;

  // negative to zero, then drop fraction bits and saturate at 127
  function automatic logic [7:0] quantize(input acc_t sum);
    acc_t scaled;
    scaled = sum >>> `FC_FRAC_SHIFT;
    if (sum[`FC_ACC_W-1]) quantize = 8'd0;
    else if (scaled > acc_t'(127)) quantize = 8'd127;
    else quantize = scaled[7:0];
  endfunction

  assign sent = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid <= 1'b0;
    end else if (pack_go) begin
      m_valid <= 1'b1;
    end else if (sent) begin
      m_valid <= 1'b0;
    end
  end

  // byte j carries neuron j
  always_ff @(posedge clk) begin
    if (pack_go) begin
      m_data <= {quantize(acc3), quantize(acc2), quantize(acc1), quantize(acc0)};
    end
  end

endmodule

/* hw/fc_top.sv */
// fc engine top: RAMs, control, operand feed, four MAC lanes and output packer
`timescale 1ns/1ns
`include "fc_config.svh"

module fc_top (
  input  logic           clk,
  input  logic           rstn,
  input  logic           cmd_valid,
  input  fc_pkg::cmd_e   cmd,
  input  fc_pkg::count_t feat_count,
  input  logic           s_valid,
  input  fc_pkg::word_t  s_data,
  input  logic           s_last,
  output logic           s_ready,
  output logic           m_valid,
  output fc_pkg::word_t  m_data,
  input  logic           m_ready,
  output logic           load_done,
  output logic           run_done
);
  import fc_pkg::*;

  addr_t                ram_addr;
  logic                 feat_we;
  logic [`FC_LANES-1:0] wt_we;
  logic                 ram_en;
  logic                 fetch;
  logic                 fetch_first;
  logic                 fetch_last;
  logic                 pack_go;
  logic                 feed_idle;
  logic                 sent;
  logic                 lane_valid;
  logic                 first_word;
  word_t                feat_word;
  word_t                wt_word [`FC_LANES];
  byte_t                feat_byte;
  byte_t                wt_byte [`FC_LANES];
  acc_t                 acc [`FC_LANES];

  fc_ctrl u_ctrl (
    .clk(clk), .rstn(rstn), .cmd_valid(cmd_valid), .cmd(cmd), .feat_count(feat_count),
    .s_valid(s_valid), .s_last(s_last), .feed_idle(feed_idle), .sent(sent),
    .s_ready(s_ready), .ram_addr(ram_addr), .feat_we(feat_we), .wt_we(wt_we),
    .ram_en(ram_en), .fetch(fetch), .fetch_first(fetch_first), .fetch_last(fetch_last),
    .pack_go(pack_go), .load_done(load_done), .run_done(run_done)
  );

  // stream data goes straight to every RAM, write enables pick the target
  word_ram #(.DEPTH(`FC_FEAT_DEPTH)) u_feat_ram (
    .clk(clk), .en(ram_en), .we(feat_we), .addr(ram_addr), .din(s_data), .dout(feat_word)
  );

  for (genvar j = 0; j < `FC_LANES; j++) begin : g_bank
    word_ram #(.DEPTH(`FC_FEAT_DEPTH)) u_wt_ram (
      .clk(clk), .en(ram_en), .we(wt_we[j]), .addr(ram_addr), .din(s_data), .dout(wt_word[j])
    );
  end

  operand_feed u_feed (
    .clk(clk), .rstn(rstn), .fetch(fetch), .fetch_first(fetch_first),
    .fetch_last(fetch_last), .feat_word(feat_word),
    .wt_word0(wt_word[0]), .wt_word1(wt_word[1]), .wt_word2(wt_word[2]), .wt_word3(wt_word[3]),
    .lane_valid(lane_valid), .first_word(first_word), .feat_byte(feat_byte),
    .wt_byte0(wt_byte[0]), .wt_byte1(wt_byte[1]), .wt_byte2(wt_byte[2]), .wt_byte3(wt_byte[3]),
    .feed_idle(feed_idle)
  );

  for (genvar j = 0; j < `FC_LANES; j++) begin : g_lane
    mac_pe u_mac (
      .clk(clk), .rstn(rstn), .in_valid(lane_valid), .first(first_word),
      .a(feat_byte), .b(wt_byte[j]), .acc(acc[j])
    );
  end

  result_pack u_pack (
    .clk(clk), .rstn(rstn), .pack_go(pack_go),
    .acc0(acc[0]), .acc1(acc[1]), .acc2(acc[2]), .acc3(acc[3]),
    .m_ready(m_ready), .m_valid(m_valid), .m_data(m_data), .sent(sent)
  );

endmodule

/* testbench/tb_clock.sv */
// testbench clock source, free running with a 10 ns period
`timescale 1ns/1ns

module tb_clock #(
  parameter int half_period = 5
) (
  output logic clk
);

  initial clk = 1'b0;

  always #half_period clk = ~clk;

endmodule

/* testbench/fc_top_properties.sv */
// fc engine protocol checks on the output stream, load pulse and reset, bound into fc_top
`timescale 1ns/1ns

module fc_top_properties (
  input logic          clk,
  input logic          rstn,
  input logic          s_ready,
  input logic          m_valid,
  input fc_pkg::word_t m_data,
  input logic          m_ready,
  input logic          load_done
);

  // output word held while the sink stalls
  hold_output: assert property (@(posedge clk) disable iff (!rstn)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("m_valid dropped or m_data changed while m_ready was low");

  load_pulse: assert property (@(posedge clk) disable iff (!rstn)
    load_done |=> !load_done)  // one cycle only
    else $error("load_done stayed high for more than one cycle");

  // nothing is accepted right out of reset
  ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !s_ready)
    else $error("s_ready high in the first cycle after reset release");

endmodule

bind fc_top fc_top_properties u_props (
  .clk(clk), .rstn(rstn), .s_ready(s_ready), .m_valid(m_valid),
  .m_data(m_data), .m_ready(m_ready), .load_done(load_done)
);

/* testbench/tb_fc_top.sv */
// fc engine testbench with directed loads and runs checked against a dot-product model
`timescale 1ns/1ns
`include "fc_config.svh"

module tb_fc_top;
  import fc_pkg::*;

  localparam int wait_limit = 2000;  // cycles per wait
  localparam int max_feat   = 64;

  logic   clk;
  logic   rstn;
  logic   cmd_valid;
  cmd_e   cmd;
  count_t feat_count;
  logic   s_valid;
  word_t  s_data;
  logic   s_last;
  logic   s_ready;
  logic   m_valid;
  word_t  m_data;
  logic   m_ready;
  logic   load_done;
  logic   run_done;

  logic [31:0] rng;
  byte_t       feat_b [max_feat];
  byte_t       wt_b [`FC_LANES][max_feat];
  word_t       tx_q [$];  // words of the load in progress
  word_t       got;

  tb_clock u_clock (.clk(clk));

  fc_top dut0 (.*);

  //////////////////////////////
  // reporting and model
  //////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic compare(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      report_error($sformatf("mismatch in %s: expected %h, actual %h", test, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_byte(output byte_t b);
    rng = xorshift32(rng);
    b   = byte_t'(rng[7:0]);
  endtask

  // per neuron dot product with negatives to 0, fraction bits dropped and a cap at 127
  function automatic word_t expected_word(input int n);
    word_t w;
    int    sum;
    int    q;
    w = '0;
    for (int j = 0; j < `FC_LANES; j++) begin
      sum = 0;
      for (int i = 0; i < n; i++) begin
        sum += int'(feat_b[i]) * int'(wt_b[j][i]);
      end
      if (sum < 0) q = 0;
      else q = sum / (1 << `FC_FRAC_SHIFT);
      if (q > 127) q = 127;
      w[8*j +: 8] = q[7:0];
    end
    return w;
  endfunction

  //////////////////////////////
  // bus helpers
  //////////////////////////////

  task automatic send_cmd(input cmd_e c, input int n);
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd        <= c;
    feat_count <= count_t'(n);
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic stream_words(input string test);
    int idx;
    int waited;
    idx    = 0;
    waited = 0;
    s_valid <= 1'b1;
    s_data  <= tx_q[0];
    s_last  <= (tx_q.size() == 1);
    while (idx < tx_q.size()) begin
      @(posedge clk);
      if (s_ready) begin  // beat taken on this edge
        idx++;
        waited = 0;
        if (idx < tx_q.size()) begin
          s_data <= tx_q[idx];
          s_last <= (idx == tx_q.size() - 1);
        end else begin
          s_valid <= 1'b0;
          s_last  <= 1'b0;
        end
      end else begin
        waited++;
        if (waited > wait_limit) report_error($sformatf("%s: s_ready never came up", test));
      end
    end
  endtask

  task automatic wait_load_done(input string test);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!load_done) begin
      waited++;
      if (waited > wait_limit) report_error($sformatf("%s: load_done never pulsed", test));
      @(posedge clk);
    end
    compare(test, 32'd0, {31'd0, s_ready});  // ready drops with the pulse
  endtask

  task automatic load_features(input string test, input int n);
    tx_q.delete();
    for (int k = 0; k < n / 4; k++) begin
      tx_q.push_back({feat_b[4*k+3], feat_b[4*k+2], feat_b[4*k+1], feat_b[4*k]});
    end
    send_cmd(load_feat, n);
    stream_words(test);
    wait_load_done(test);
  endtask

  // banks 0..3 back to back with the lowest byte first
  task automatic load_weights(input string test, input int n);
    tx_q.delete();
    for (int j = 0; j < `FC_LANES; j++) begin
      for (int k = 0; k < n / 4; k++) begin
        tx_q.push_back({wt_b[j][4*k+3], wt_b[j][4*k+2], wt_b[j][4*k+1], wt_b[j][4*k]});
      end
    end
    send_cmd(load_wt, n);
    stream_words(test);
    wait_load_done(test);
  endtask

  task automatic run_until_valid(input string test, input int n);
    int waited;
    waited = 0;
    send_cmd(run, n);
    @(posedge clk);
    while (!m_valid) begin
      waited++;
      if (waited > wait_limit) report_error($sformatf("%s: m_valid never rose", test));
      @(posedge clk);
    end
    got = m_data;
    compare(test, expected_word(n), got);
  endtask

  task automatic wait_run_done(input string test);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!run_done) begin
      waited++;
      if (waited > wait_limit) report_error($sformatf("%s: run_done never pulsed", test));
      @(posedge clk);
    end
  endtask

  task automatic randomize_vectors(input int n);
    for (int i = 0; i < n; i++) begin
      next_byte(feat_b[i]);
      for (int j = 0; j < `FC_LANES; j++) next_byte(wt_b[j][i]);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic small_dot_product();
    for (int i = 0; i < 4; i++) begin
      feat_b[i]  = byte_t'(i + 1);
      wt_b[0][i] = (i == 0) ? 8'sd64 : 8'sd0;
      wt_b[1][i] = 8'sd32;
      wt_b[2][i] = 8'sd16;
    end
    wt_b[3][0] = -8'sd8;
    wt_b[3][1] = 8'sd64;
    wt_b[3][2] = 8'sd10;
    wt_b[3][3] = 8'sd20;
    load_features("small", 4);
    load_weights("small", 4);
    run_until_valid("small", 4);
    compare("small", 32'h03020501, got);  // sums 64, 320, 160, 230
    wait_run_done("small");
  endtask

  task automatic random_dot_product();
    randomize_vectors(16);
    load_features("random", 16);
    load_weights("random", 16);
    run_until_valid("random", 16);
    wait_run_done("random");
  endtask

  // features stay from random_dot_product
  task automatic feature_reuse();
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < `FC_LANES; j++) next_byte(wt_b[j][i]);
    end
    load_weights("reuse", 16);
    run_until_valid("reuse", 16);
    wait_run_done("reuse");
  endtask

  task automatic negative_clip();
    randomize_vectors(8);
    for (int i = 0; i < 8; i++) begin
      feat_b[i]  = byte_t'((feat_b[i] & 8'h7f) | 8'h01);  // strictly positive
      wt_b[0][i] = -8'sd50;
    end
    load_features("negative", 8);
    load_weights("negative", 8);
    run_until_valid("negative", 8);
    compare("negative", 32'd0, {24'd0, got[7:0]});
    wait_run_done("negative");
  endtask

  task automatic saturation_cap();
    randomize_vectors(8);
    for (int i = 0; i < 8; i++) begin
      feat_b[i]  = 8'sd100;
      wt_b[0][i] = 8'sd100;  // 80000 >> 6 is far above 127
    end
    load_features("saturate", 8);
    load_weights("saturate", 8);
    run_until_valid("saturate", 8);
    compare("saturate", 32'd127, {24'd0, got[7:0]});
    wait_run_done("saturate");
  endtask

  task automatic output_stall();
    word_t held;
    m_ready <= 1'b0;
    run_until_valid("backpressure", 8);
    held = got;
    repeat (6) begin
      @(posedge clk);
      compare("backpressure", 32'd1, {31'd0, m_valid});
      compare("backpressure", held, m_data);
      compare("backpressure", 32'd0, {31'd0, run_done});
    end
    m_ready <= 1'b1;
    wait_run_done("backpressure");
  endtask

  initial begin
    rng        = 32'h6f0c5920;
    rstn       = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = load_feat;
    feat_count = '0;
    s_valid    = 1'b0;
    s_data     = '0;
    s_last     = 1'b0;
    m_ready    = 1'b1;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    small_dot_product();
    random_dot_product();
    feature_reuse();
    negative_clip();
    saturation_cap();
    output_stall();

    $display("All tests passed!");
    $finish;
  end

endmodule

/* fc_top.f */
+incdir+hw
hw/fc_pkg.sv
hw/word_ram.sv
hw/fc_ctrl.sv
hw/operand_feed.sv
hw/mac_pe.sv
hw/result_pack.sv
hw/fc_top.sv
testbench/tb_clock.sv
testbench/fc_top_properties.sv
testbench/tb_fc_top.sv

/* Makefile */
SIM      := verilator
TOP      := tb_fc_top
FILELIST := fc_top.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
